//--- bypassNetwork.sv
`timescale 1ns/1ps
`default_nettype none

module bypassNetwork import isaPkg::*, pipePkg::*; (
	input  logic [regIdxW-1:0] exRs,
	input  logic [regIdxW-1:0] exRt,
	input  logic [regIdxW-1:0] idRs,
	input  logic [regIdxW-1:0] idRt,
	input  opClassE            idClass,
	input  logic [regIdxW-1:0] mem1Dst,
	input  logic [regIdxW-1:0] mem2Dst,
	input  logic [regIdxW-1:0] wbDst,
	input  logic               mem1Wr,
	input  logic               mem2Wr,
	input  logic               wbWr,
	input  opClassE            mem1Class,
	input  logic [dataW-1:0]   mem1Result,
	input  logic [dataW-1:0]   mem2Result,
	input  logic [dataW-1:0]   wbResult,
	input  logic [dataW-1:0]   rfExRs,
	input  logic [dataW-1:0]   rfExRt,
	input  logic [dataW-1:0]   rfIdRs,
	input  logic [dataW-1:0]   rfIdRt,
	output fwdSelE             exRsSel,
	output fwdSelE             exRtSel,
	output fwdSelE             idRsSel,
	output fwdSelE             idRtSel,
	output logic [dataW-1:0]   exRsValue,
	output logic [dataW-1:0]   exRtValue,
	output logic [dataW-1:0]   idRsValue,
	output logic [dataW-1:0]   idRtValue
);

	// Youngest matching producer wins
	function automatic fwdSelE pickSel(logic [regIdxW-1:0] idx, logic withWb);
		if (mem1Wr && mem1Class != opStoreCond && mem1Dst != regZero && mem1Dst == idx)
			return fwdMem1; // SC status not ready yet
		else if (mem2Wr && mem2Dst != regZero && mem2Dst == idx)
			return fwdMem2;
		else if (withWb && wbWr && wbDst != regZero && wbDst == idx)
			return fwdWb;
		return fwdNone;
	endfunction

	function automatic logic [dataW-1:0] pickValue(fwdSelE sel, logic [dataW-1:0] rfData);
		case (sel)
			fwdMem1: return mem1Result;
			fwdMem2: return mem2Result;
			fwdWb:   return wbResult;
			default: return rfData;
		endcase
	endfunction

	always_comb begin
		exRsSel = pickSel(exRs, 1'b1);
		exRtSel = pickSel(exRt, 1'b1);
		idRsSel = (idClass == opBranch) ? pickSel(idRs, 1'b0) : fwdNone; // Compare in ID
		idRtSel = (idClass inside {opBranch, opMovCond}) ? pickSel(idRt, 1'b0) : fwdNone;
	end

	always_comb begin
		exRsValue = pickValue(exRsSel, rfExRs);
		exRtValue = pickValue(exRtSel, rfExRt);
		idRsValue = pickValue(idRsSel, rfIdRs);
		idRtValue = pickValue(idRtSel, rfIdRt);
	end

endmodule

`default_nettype wire

//--- hazardGolden.txt
// Stimulus, hex: idRs idRt idRd idClass exResult loadData memBusy mulBusy flush
// Expected: enables(pc ifId idEx exMem1 mem1Mem2 mem2Wb) cause exRsSel exRtSel idRsSel idRtSel
// then exRsValue exRtValue idRsValue idRtValue
01 02 05 0 00000000 00000000 0 0 0 3f 0 0 0 0 0 00000000 00000000 00000000 00000000
05 04 05 0 11111111 00000000 0 0 0 3f 0 0 0 0 0 00000000 00000000 00000000 00000000
06 07 05 0 22222222 00000000 0 0 0 3f 0 1 0 0 0 11111111 00000000 00000000 00000000
05 00 06 0 33333333 00000000 0 0 0 3f 0 0 0 0 0 00000000 00000000 00000000 00000000
05 05 00 0 44444444 00000000 0 0 0 3f 0 1 0 0 0 33333333 00000000 00000000 00000000
00 05 07 0 55555555 00000000 0 0 0 3f 0 2 2 0 0 33333333 33333333 00000000 11111111
00 00 08 0 66666666 00000000 0 0 0 3f 0 0 3 0 0 00000000 33333333 00000000 00000000
00 00 08 3 77777777 00000000 0 0 0 3f 0 0 0 0 0 00000000 00000000 00000000 00000000
08 06 00 4 00000001 00000000 0 0 0 0f 5 0 0 1 0 00000000 00000000 77777777 44444444
08 06 00 4 00000000 00000000 0 0 0 0f 5 0 0 2 0 00000000 00000000 77777777 44444444
08 06 00 4 00000000 00000000 0 0 0 3f 0 0 0 2 0 00000000 00000000 00000001 44444444
00 00 09 1 00000000 00000000 0 0 0 3f 0 3 0 0 0 00000001 44444444 00000000 00000000
09 08 0a 0 00001000 00000000 0 0 0 0f 5 0 0 0 0 00000000 00000000 00000000 00000001
09 08 0a 0 00000000 00000000 0 0 0 0f 5 0 0 0 0 00000000 00000000 00000000 00000001
09 08 0a 0 00000000 cafef00d 0 0 0 3f 0 0 0 0 0 00000000 00000000 00000000 00000001
0a 09 00 4 12345678 00000000 0 0 0 0f 5 3 0 0 0 cafef00d 00000001 00000000 00000000
0a 09 00 4 00000000 00000000 0 0 0 3f 0 0 0 1 0 00000000 00000000 12345678 cafef00d
0a 0a 0b 5 00000000 00000000 0 0 0 3f 0 2 0 0 2 12345678 cafef00d 00000000 12345678
05 06 00 6 0000beef 00000000 0 0 0 3f 0 3 3 0 0 12345678 12345678 33333333 44444444
0b 00 0c 0 00000000 00000000 0 1 0 00 4 0 0 0 0 33333333 44444444 00000000 00000000
0b 00 0c 0 00000000 00000000 0 0 0 3f 0 0 0 0 0 33333333 44444444 00000000 00000000
00 00 0d 7 0000cccc 00000000 0 1 0 0f 3 2 0 0 0 0000beef 00000000 00000000 00000000
00 00 0d 7 00000000 00000000 1 0 1 3c 1 0 0 0 0 00000000 00000000 00000000 00000000
0b 0c 0d 0 00000000 00000000 1 0 0 00 2 0 0 0 0 00000000 00000000 0000beef 00000000
0b 0c 0d 0 00000000 00000000 1 0 0 00 2 0 0 0 0 00000000 00000000 0000beef 00000000
0b 0c 0d 0 00000000 00000000 0 0 0 3f 0 0 0 0 0 00000000 00000000 0000beef 00000000
00 0a 00 0 00000000 00000000 0 0 0 3f 0 0 0 0 0 0000beef 00000000 00000000 12345678

//--- hazardTb.sv
`timescale 1ns/1ps
`default_nettype none

module hazardTb import isaPkg::*, pipePkg::*; ();

	localparam int vecCount   = 27;
	localparam int fieldCount = 19; // Words per golden line
	localparam int cycleLimit = vecCount + 20;

	logic               clk = 1'b0;
	logic               rstN;
	logic [regIdxW-1:0] idRs;
	logic [regIdxW-1:0] idRt;
	logic [regIdxW-1:0] idRd;
	opClassE            idClass;
	logic [dataW-1:0]   exResult;
	logic [dataW-1:0]   loadData;
	logic               memBusy;
	logic               mulBusy;
	logic               flush;
	logic               pcWr;
	logic               ifIdWr;
	logic               idExWr;
	logic               exMem1Wr;
	logic               mem1Mem2Wr;
	logic               mem2WbWr;
	stallCauseE         stallCause;
	fwdSelE             exRsSel;
	fwdSelE             exRtSel;
	fwdSelE             idRsSel;
	fwdSelE             idRtSel;
	logic [dataW-1:0]   exRsValue;
	logic [dataW-1:0]   exRtValue;
	logic [dataW-1:0]   idRsValue;
	logic [dataW-1:0]   idRtValue;

	logic [31:0] golden [vecCount*fieldCount];
	int          cycleCount  = 0;
	int          vecIdx      = 0;
	int          enErrors    = 0;
	int          causeErrors = 0;
	int          selErrors   = 0;
	int          valueErrors = 0;
	logic        loadFailed  = 1'b0;

	hazardTop dut0 (
		.clk(clk), .rstN(rstN),
		.idRs(idRs), .idRt(idRt), .idRd(idRd), .idClass(idClass),
		.exResult(exResult), .loadData(loadData),
		.memBusy(memBusy), .mulBusy(mulBusy), .flush(flush),
		.pcWr(pcWr), .ifIdWr(ifIdWr), .idExWr(idExWr),
		.exMem1Wr(exMem1Wr), .mem1Mem2Wr(mem1Mem2Wr), .mem2WbWr(mem2WbWr),
		.stallCause(stallCause),
		.exRsSel(exRsSel), .exRtSel(exRtSel), .idRsSel(idRsSel), .idRtSel(idRtSel),
		.exRsValue(exRsValue), .exRtValue(exRtValue),
		.idRsValue(idRsValue), .idRtValue(idRtValue)
	);

	always #2 clk = ~clk; // 4 ns period

	initial begin
		while (cycleCount < cycleLimit) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
		$display("*** TEST FAILED ***");
		$finish;
	end

	task automatic checkEnables(input logic [5:0] got, input logic [5:0] exp);
		if (got !== exp) begin
			enErrors++;
			$display("ERROR %0t: vector %0d enables %b, expected %b", $time, vecIdx, got, exp);
		end
	endtask

	task automatic checkCause(input stallCauseE got, input stallCauseE exp);
		if (got !== exp) begin
			causeErrors++;
			$display("ERROR %0t: vector %0d stallCause %s, expected %s",
				$time, vecIdx, got.name(), exp.name());
		end
	endtask

	task automatic checkSel(input string what, input fwdSelE got, input fwdSelE exp);
		if (got !== exp) begin
			selErrors++;
			$display("ERROR %0t: vector %0d %s %s, expected %s",
				$time, vecIdx, what, got.name(), exp.name());
		end
	endtask

	task automatic checkValue(input string what, input logic [dataW-1:0] got,
			input logic [dataW-1:0] exp);
		if (got !== exp) begin
			valueErrors++;
			$display("ERROR %0t: vector %0d %s %h, expected %h",
				$time, vecIdx, what, got, exp);
		end
	endtask

	task automatic driveVector(input int v);
		int base;
		base = v * fieldCount;
		idRs     <= golden[base][regIdxW-1:0];
		idRt     <= golden[base+1][regIdxW-1:0];
		idRd     <= golden[base+2][regIdxW-1:0];
		idClass  <= opClassE'(golden[base+3][3:0]);
		exResult <= golden[base+4];
		loadData <= golden[base+5];
		memBusy  <= golden[base+6][0];
		mulBusy  <= golden[base+7][0];
		flush    <= golden[base+8][0];
	endtask

	task automatic checkOutputs(input int v);
		int base;
		base = v * fieldCount + 9; // First expected column
		vecIdx = v;
		checkEnables({pcWr, ifIdWr, idExWr, exMem1Wr, mem1Mem2Wr, mem2WbWr}, golden[base][5:0]);
		checkCause(stallCause, stallCauseE'(golden[base+1][2:0]));
		checkSel("exRsSel", exRsSel, fwdSelE'(golden[base+2][1:0]));
		checkSel("exRtSel", exRtSel, fwdSelE'(golden[base+3][1:0]));
		checkSel("idRsSel", idRsSel, fwdSelE'(golden[base+4][1:0]));
		checkSel("idRtSel", idRtSel, fwdSelE'(golden[base+5][1:0]));
		checkValue("exRsValue", exRsValue, golden[base+6]);
		checkValue("exRtValue", exRtValue, golden[base+7]);
		checkValue("idRsValue", idRsValue, golden[base+8]);
		checkValue("idRtValue", idRtValue, golden[base+9]);
	endtask

	initial begin
		int v;
		rstN     = 1'b0;
		idRs     = '0;
		idRt     = '0;
		idRd     = '0;
		idClass  = opNone; // Idle ID stage
		exResult = '0;
		loadData = '0;
		memBusy  = 1'b0;
		mulBusy  = 1'b0;
		flush    = 1'b0;
		$readmemh("hazardGolden.txt", golden);
		if ($isunknown(golden[vecCount*fieldCount-1])) begin
			loadFailed = 1'b1;
			$display("The golden vector file is missing or holds fewer than %0d vectors",
				vecCount);
		end
		repeat (5) @(posedge clk);
		rstN <= 1'b1;
		for (v = 0; v < vecCount; v++) begin
			@(posedge clk);
			driveVector(v);
			@(negedge clk); // Outputs settled by mid cycle
			checkOutputs(v);
		end
		$display("Vectors %0d, errors: enables %0d, cause %0d, select %0d, value %0d",
			vecCount, enErrors, causeErrors, selErrors, valueErrors);
		if (!loadFailed && enErrors + causeErrors + selErrors + valueErrors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- hazardTop.sv
`timescale 1ns/1ps
`default_nettype none

module hazardTop import isaPkg::*, pipePkg::*; (
	input  logic               clk,
	input  logic               rstN,
	input  logic [regIdxW-1:0] idRs,
	input  logic [regIdxW-1:0] idRt,
	input  logic [regIdxW-1:0] idRd,
	input  opClassE            idClass,
	input  logic [dataW-1:0]   exResult,
	input  logic [dataW-1:0]   loadData,
	input  logic               memBusy,
	input  logic               mulBusy,
	input  logic               flush,
	output logic               pcWr,
	output logic               ifIdWr,
	output logic               idExWr,
	output logic               exMem1Wr,
	output logic               mem1Mem2Wr,
	output logic               mem2WbWr,
	output stallCauseE         stallCause,
	output fwdSelE             exRsSel,
	output fwdSelE             exRtSel,
	output fwdSelE             idRsSel,
	output fwdSelE             idRtSel,
	output logic [dataW-1:0]   exRsValue,
	output logic [dataW-1:0]   exRtValue,
	output logic [dataW-1:0]   idRsValue,
	output logic [dataW-1:0]   idRtValue
);

	logic [regIdxW-1:0] exRs;
	logic [regIdxW-1:0] exRt;
	logic [regIdxW-1:0] exDst;
	logic [regIdxW-1:0] mem1Dst;
	logic [regIdxW-1:0] mem2Dst;
	logic [regIdxW-1:0] wbDst;
	opClassE            exClass;
	opClassE            mem1Class;
	opClassE            mem2Class;
	logic               exWr;
	logic               mem1Wr;
	logic               mem2Wr;
	logic               wbWr;
	logic [dataW-1:0]   mem1Result;
	logic [dataW-1:0]   mem2Result;
	logic [dataW-1:0]   wbResult;
	logic [dataW-1:0]   rfExRs;
	logic [dataW-1:0]   rfExRt;
	logic [dataW-1:0]   rfIdRs;
	logic [dataW-1:0]   rfIdRt;

	stageTracker tracker0 (
		.clk(clk), .rstN(rstN),
		.idRs(idRs), .idRt(idRt), .idRd(idRd), .idClass(idClass),
		.exResult(exResult), .loadData(loadData),
		.flush(flush), .ifIdWr(ifIdWr), .idExWr(idExWr),
		.exMem1Wr(exMem1Wr), .mem1Mem2Wr(mem1Mem2Wr), .mem2WbWr(mem2WbWr),
		.exRs(exRs), .exRt(exRt),
		.exDst(exDst), .mem1Dst(mem1Dst), .mem2Dst(mem2Dst), .wbDst(wbDst),
		.exClass(exClass), .mem1Class(mem1Class), .mem2Class(mem2Class),
		.exWr(exWr), .mem1Wr(mem1Wr), .mem2Wr(mem2Wr), .wbWr(wbWr),
		.mem1Result(mem1Result), .mem2Result(mem2Result), .wbResult(wbResult)
	);

	regFile regs0 (
		.clk(clk), .rstN(rstN),
		.we(wbWr && wbDst != regZero), .waddr(wbDst), .wdata(wbResult), // WB write port
		.raddrA(exRs), .raddrB(exRt), .raddrC(idRs), .raddrD(idRt),
		.rdataA(rfExRs), .rdataB(rfExRt), .rdataC(rfIdRs), .rdataD(rfIdRt)
	);

	bypassNetwork bypass0 (
		.exRs(exRs), .exRt(exRt), .idRs(idRs), .idRt(idRt), .idClass(idClass),
		.mem1Dst(mem1Dst), .mem2Dst(mem2Dst), .wbDst(wbDst),
		.mem1Wr(mem1Wr), .mem2Wr(mem2Wr), .wbWr(wbWr), .mem1Class(mem1Class),
		.mem1Result(mem1Result), .mem2Result(mem2Result), .wbResult(wbResult),
		.rfExRs(rfExRs), .rfExRt(rfExRt), .rfIdRs(rfIdRs), .rfIdRt(rfIdRt),
		.exRsSel(exRsSel), .exRtSel(exRtSel), .idRsSel(idRsSel), .idRtSel(idRtSel),
		.exRsValue(exRsValue), .exRtValue(exRtValue),
		.idRsValue(idRsValue), .idRtValue(idRtValue)
	);

	stallControl stall0 (
		.idRs(idRs), .idRt(idRt), .idClass(idClass),
		.exDst(exDst), .mem1Dst(mem1Dst), .mem2Dst(mem2Dst),
		.exClass(exClass), .mem1Class(mem1Class), .mem2Class(mem2Class),
		.exWr(exWr), .mem1Wr(mem1Wr), .mem2Wr(mem2Wr),
		.flush(flush), .memBusy(memBusy), .mulBusy(mulBusy),
		.pcWr(pcWr), .ifIdWr(ifIdWr), .idExWr(idExWr),
		.exMem1Wr(exMem1Wr), .mem1Mem2Wr(mem1Mem2Wr), .mem2WbWr(mem2WbWr),
		.stallCause(stallCause)
	);

endmodule

`default_nettype wire

//--- isaPkg.sv
`default_nettype none

package isaPkg;

	localparam int regIdxW = 5;
	localparam int regCount = 1 << regIdxW;
	localparam logic [regIdxW-1:0] regZero = '0; // Hard-wired zero register

	typedef enum logic [3:0] {
		opAlu        = 4'd0,
		opLoad       = 4'd1,
		opCp0Read    = 4'd2,
		opStoreCond  = 4'd3, // SC writes its status to rt
		opBranch     = 4'd4,
		opMovCond    = 4'd5, // MOVN and MOVZ
		opMulDiv     = 4'd6,
		opHiloAccess = 4'd7, // MFHI, MFLO, MTHI, MTLO
		opNone       = 4'd8  // Bubble or empty stage
	} opClassE;

	// Classes that end with a GPR write
	function automatic logic writesReg(opClassE cls);
		return cls inside {opAlu, opLoad, opCp0Read, opStoreCond, opMovCond};
	endfunction

	// Result is known only after the memory stages
	function automatic logic lateResult(opClassE cls);
		return cls inside {opLoad, opCp0Read, opStoreCond};
	endfunction

	function automatic logic readsMemData(opClassE cls);
		return cls inside {opLoad, opCp0Read};
	endfunction

endpackage

`default_nettype wire

//--- pipePkg.sv
`default_nettype none

package pipePkg;

	localparam int dataW = 32;

	// Source of a forwarded operand
	typedef enum logic [2-1:0] {
		fwdNone = 2'd0, // Register file value
		fwdMem1 = 2'd1,
		fwdMem2 = 2'd2,
		fwdWb   = 2'd3
	} fwdSelE;

	// Stall table rows in priority order
	typedef enum logic [2:0] {
		causeNone   = 3'd0,
		causeFlush  = 3'd1,
		causeMem    = 3'd2,
		causeHilo   = 3'd3,
		causeMulDiv = 3'd4,
		causeData   = 3'd5
	} stallCauseE;

endpackage

`default_nettype wire

//--- regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile import isaPkg::*, pipePkg::*; (
	input  logic               clk,
	input  logic               rstN,
	input  logic               we,
	input  logic [regIdxW-1:0] waddr,
	input  logic [dataW-1:0]   wdata,
	input  logic [regIdxW-1:0] raddrA,
	input  logic [regIdxW-1:0] raddrB,
	input  logic [regIdxW-1:0] raddrC,
	input  logic [regIdxW-1:0] raddrD,
	output logic [dataW-1:0]   rdataA,
	output logic [dataW-1:0]   rdataB,
	output logic [dataW-1:0]   rdataC,
	output logic [dataW-1:0]   rdataD
);

	logic [dataW-1:0] regs [regCount];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != regZero) begin
			regs[waddr] <= wdata;
		end
	end

	// Old value is seen during a same-edge write
	assign rdataA = (raddrA == regZero) ? '0 : regs[raddrA]; // EX rs
	assign rdataB = (raddrB == regZero) ? '0 : regs[raddrB]; // EX rt
	assign rdataC = (raddrC == regZero) ? '0 : regs[raddrC]; // ID rs
	assign rdataD = (raddrD == regZero) ? '0 : regs[raddrD]; // ID rt

endmodule

`default_nettype wire

//--- src.f
isaPkg.sv
pipePkg.sv
regFile.sv
stageTracker.sv
bypassNetwork.sv
stallControl.sv
hazardTop.sv
hazardTb.sv

//--- stageTracker.sv
`timescale 1ns/1ps
`default_nettype none

module stageTracker import isaPkg::*, pipePkg::*; (
	input  logic               clk,
	input  logic               rstN,
	input  logic [regIdxW-1:0] idRs,
	input  logic [regIdxW-1:0] idRt,
	input  logic [regIdxW-1:0] idRd,
	input  opClassE            idClass,
	input  logic [dataW-1:0]   exResult,
	input  logic [dataW-1:0]   loadData,
	input  logic               flush,
	input  logic               ifIdWr,
	input  logic               idExWr,
	input  logic               exMem1Wr,
	input  logic               mem1Mem2Wr,
	input  logic               mem2WbWr,
	output logic [regIdxW-1:0] exRs,
	output logic [regIdxW-1:0] exRt,
	output logic [regIdxW-1:0] exDst,
	output logic [regIdxW-1:0] mem1Dst,
	output logic [regIdxW-1:0] mem2Dst,
	output logic [regIdxW-1:0] wbDst,
	output opClassE            exClass,
	output opClassE            mem1Class,
	output opClassE            mem2Class,
	output logic               exWr,
	output logic               mem1Wr,
	output logic               mem2Wr,
	output logic               wbWr,
	output logic [dataW-1:0]   mem1Result,
	output logic [dataW-1:0]   mem2Result,
	output logic [dataW-1:0]   wbResult
);

	logic [dataW-1:0] mem2Held; // Result carried from EX

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			exRs      <= regZero;
			exRt      <= regZero;
			exDst     <= regZero;
			exClass   <= opNone;
			exWr      <= 1'b0;
			mem1Dst   <= regZero;
			mem1Class <= opNone;
			mem1Wr    <= 1'b0;
			mem2Dst   <= regZero;
			mem2Class <= opNone;
			mem2Wr    <= 1'b0;
			wbDst     <= regZero;
			wbWr      <= 1'b0;
		end else begin
			if (flush || (idExWr && !ifIdWr)) begin // Squash or bubble
				exRs    <= regZero;
				exRt    <= regZero;
				exDst   <= regZero;
				exClass <= opNone;
				exWr    <= 1'b0;
			end else if (idExWr) begin
				exRs    <= idRs;
				exRt    <= idRt;
				exDst   <= idRd;
				exClass <= idClass;
				exWr    <= writesReg(idClass);
			end

			if (flush) begin
				mem1Dst   <= regZero;
				mem1Class <= opNone;
				mem1Wr    <= 1'b0;
			end else if (exMem1Wr) begin
				mem1Dst   <= exDst;
				mem1Class <= exClass;
				mem1Wr    <= exWr;
			end

			// Back end keeps draining through a flush
			if (mem1Mem2Wr) begin
				mem2Dst   <= mem1Dst;
				mem2Class <= mem1Class;
				mem2Wr    <= mem1Wr;
			end

			if (mem2WbWr) begin
				wbDst <= mem2Dst;
				wbWr  <= mem2Wr;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (exMem1Wr) begin
			mem1Result <= exResult;
		end
		if (mem1Mem2Wr) begin
			mem2Held <= mem1Result;
		end
		if (mem2WbWr) begin
			wbResult <= mem2Result;
		end
	end

	// Cache returns load data in MEM2
	assign mem2Result = readsMemData(mem2Class) ? loadData : mem2Held;

endmodule

`default_nettype wire

//--- stallControl.sv
`timescale 1ns/1ps
`default_nettype none

module stallControl import isaPkg::*, pipePkg::*; (
	input  logic [regIdxW-1:0] idRs,
	input  logic [regIdxW-1:0] idRt,
	input  opClassE            idClass,
	input  logic [regIdxW-1:0] exDst,
	input  logic [regIdxW-1:0] mem1Dst,
	input  logic [regIdxW-1:0] mem2Dst,
	input  opClassE            exClass,
	input  opClassE            mem1Class,
	input  opClassE            mem2Class,
	input  logic               exWr,
	input  logic               mem1Wr,
	input  logic               mem2Wr,
	input  logic               flush,
	input  logic               memBusy,
	input  logic               mulBusy,
	output logic               pcWr,
	output logic               ifIdWr,
	output logic               idExWr,
	output logic               exMem1Wr,
	output logic               mem1Mem2Wr,
	output logic               mem2WbWr,
	output stallCauseE         stallCause
);

	logic       exHitsId;
	logic       mem1HitsId;
	logic       mem2HitsId;
	logic       idEarly;
	logic       dataHazard;
	logic [5:0] en; // pc, ifId, idEx, exMem1, mem1Mem2, mem2Wb

	assign exHitsId   = (exDst == idRs) || (exDst == idRt);
	assign mem1HitsId = (mem1Dst == idRs) || (mem1Dst == idRt);
	assign mem2HitsId = (mem2Dst == idRs) || (mem2Dst == idRt);
	assign idEarly    = idClass inside {opBranch, opMovCond}; // Operands needed in ID

	assign dataHazard =
		(exWr && lateResult(exClass) && exHitsId) ||
		(mem1Wr && lateResult(mem1Class) && mem1HitsId) ||
		(idEarly && exWr && exClass != opStoreCond && exDst != regZero && exHitsId) ||
		(idEarly && mem2Wr && readsMemData(mem2Class) && mem2Dst != regZero && mem2HitsId);

	always_comb begin
		if (flush) begin
			en         = {4'b1111, !memBusy, !memBusy};
			stallCause = causeFlush;
		end else if (memBusy) begin
			en         = 6'b000000; // Freeze everything
			stallCause = causeMem;
		end else if (mulBusy && idClass == opHiloAccess) begin
			en         = 6'b001111;
			stallCause = causeHilo;
		end else if (mulBusy && exClass == opMulDiv) begin
			en         = 6'b000000;
			stallCause = causeMulDiv;
		end else if (dataHazard) begin
			en         = 6'b001111; // Bubble into EX
			stallCause = causeData;
		end else begin
			en         = 6'b111111;
			stallCause = causeNone;
		end
	end

	assign {pcWr, ifIdWr, idExWr, exMem1Wr, mem1Mem2Wr, mem2WbWr} = en;

endmodule

`default_nettype wire
